//--- Makefile
# Verilator build and run of the heap unit testbench

VERILATOR ?= verilator
TOP       ?= heapUnitTb
LOG       ?= sim.log
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f list.f
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
	  echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- list.f
+incdir+src
src/heapPkg.sv
src/heapStore.sv
src/heapAllocator.sv
src/heapEngine.sv
src/heapRegs.sv
src/heapUnit.sv
sim/heapUnit_checker.sv
sim/heapUnitTb.sv

//--- sim/heapUnitTb.sv
//----------------------------------------
// Array heap unit testbench
// Command table applied over AXI4-Lite
//----------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapUnitTb import heapPkg::*; ();

  localparam int                       StimDelay   = 5;
  localparam logic [`HEAP_ADDR_BITS-1:0] AddrOperand = 4'd0;
  localparam logic [`HEAP_ADDR_BITS-1:0] AddrData    = 4'd4;
  localparam logic [`HEAP_ADDR_BITS-1:0] AddrCommand = 4'd8;
  localparam logic [`HEAP_ADDR_BITS-1:0] AddrStatus  = 4'd12;
  localparam logic [1:0]               RespOkay    = 2'b00;
  localparam logic [1:0]               RespSlvErr  = 2'b10;

  logic                       clock;
  logic                       resetN;
  logic [`HEAP_ADDR_BITS-1:0] awAddr;
  logic                       awValid;
  logic                       awReady;
  logic [31:0]                wData;
  logic [3:0]                 wStrb;
  logic                       wValid;
  logic                       wReady;
  logic [1:0]                 bResp;
  logic                       bValid;
  logic                       bReady;
  logic [`HEAP_ADDR_BITS-1:0] arAddr;
  logic                       arValid;
  logic                       arReady;
  logic [31:0]                rData;
  logic [1:0]                 rResp;
  logic                       rValid;
  logic                       rReady;

  // Command table, one entry per row in each queue
  string                       nameQ[$];
  heapOp                       opQ[$];
  logic [`HEAP_ARRAY_BITS-1:0] arrayQ[$];
  logic [`HEAP_INDEX_BITS-1:0] indexQ[$];
  logic [`HEAP_DATA_BITS-1:0]  dataQ[$];
  heapErr                      errQ[$];
  logic [`HEAP_DATA_BITS-1:0]  resultQ[$];
  logic                        overlapQ[$];   // Second command while busy

  int cycles     = 0;
  int cycleLimit = 0;

  heapUnit heapUnit_inst (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycleLimit != 0 && cycles >= cycleLimit) begin
      $display("timeout: the DUT did not finish the table within %0d cycles", cycleLimit);
      reportFailure();
    end
  end

  task automatic reportFailure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic checkValue(input string test, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("error %s %s: expected 0x%0h, actual 0x%0h", test, what, expected, actual);
      reportFailure();
    end
  endtask

  //----------------------------------------
  // AXI4-Lite master
  //----------------------------------------
  task automatic writeRegister(input logic [`HEAP_ADDR_BITS-1:0] addr,
                               input logic [31:0] value, output logic [1:0] resp);
    awAddr  = addr;
    wData   = value;
    wStrb   = 4'hF;
    awValid = 1'b1;
    wValid  = 1'b1;
    do begin
      @(posedge clock);
      #StimDelay;
    end while (!(awReady && wReady));         // Handshake on the next edge
    @(posedge clock);
    #StimDelay;
    awValid = 1'b0;
    wValid  = 1'b0;
    while (!bValid) begin
      @(posedge clock);
      #StimDelay;
    end
    resp   = bResp;
    bReady = 1'b1;
    @(posedge clock);
    #StimDelay;
    bReady = 1'b0;
  endtask

  task automatic readRegister(input logic [`HEAP_ADDR_BITS-1:0] addr,
                              output logic [31:0] value, output logic [1:0] resp);
    arAddr  = addr;
    arValid = 1'b1;
    do begin
      @(posedge clock);
      #StimDelay;
    end while (!arReady);
    @(posedge clock);
    #StimDelay;
    arValid = 1'b0;
    while (!rValid) begin
      @(posedge clock);
      #StimDelay;
    end
    value  = rData;
    resp   = rResp;
    rReady = 1'b1;
    @(posedge clock);
    #StimDelay;
    rReady = 1'b0;
  endtask

  //----------------------------------------
  // Table
  //----------------------------------------
  task automatic addRow(input string name, input heapOp op,
                        input logic [`HEAP_ARRAY_BITS-1:0] arr,
                        input logic [`HEAP_INDEX_BITS-1:0] idx,
                        input logic [`HEAP_DATA_BITS-1:0] value, input heapErr err,
                        input logic [`HEAP_DATA_BITS-1:0] result, input logic overlap);
    nameQ.push_back(name);
    opQ.push_back(op);
    arrayQ.push_back(arr);
    indexQ.push_back(idx);
    dataQ.push_back(value);
    errQ.push_back(err);
    resultQ.push_back(result);
    overlapQ.push_back(overlap);
  endtask

  task automatic buildTable();
    addRow("alloc0", opAlloc, 2'd0, 3'd0, 12'h0, errNone, 12'd0, 1'b0);
    addRow("alloc1", opAlloc, 2'd0, 3'd0, 12'h0, errNone, 12'd1, 1'b0);
    addRow("alloc2", opAlloc, 2'd0, 3'd0, 12'h0, errNone, 12'd2, 1'b0);
    addRow("alloc3", opAlloc, 2'd0, 3'd0, 12'h0, errNone, 12'd3, 1'b0);
    addRow("allocNone", opAlloc, 2'd0, 3'd0, 12'h0, errOutOfMemory, 12'd0, 1'b0);
    addRow("free2", opFree, 2'd2, 3'd0, 12'h0, errNone, 12'd0, 1'b0);
    addRow("free1", opFree, 2'd1, 3'd0, 12'h0, errNone, 12'd0, 1'b0);
    addRow("reuse1", opAlloc, 2'd0, 3'd0, 12'h0, errNone, 12'd1, 1'b0);  // Latest freed
    addRow("reuse2", opAlloc, 2'd0, 3'd0, 12'h0, errNone, 12'd2, 1'b0);
    addRow("write0", opWrite, 2'd0, 3'd0, 12'h123, errNone, 12'h123, 1'b0);
    addRow("write1", opWrite, 2'd0, 3'd1, 12'h456, errNone, 12'h456, 1'b0);
    addRow("write2", opWrite, 2'd0, 3'd2, 12'hABC, errNone, 12'hABC, 1'b0);
    addRow("sizeWritten", opSize, 2'd0, 3'd0, 12'h0, errNone, 12'd3, 1'b0);
    addRow("read0", opRead, 2'd0, 3'd0, 12'h0, errNone, 12'h123, 1'b0);
    addRow("read1", opRead, 2'd0, 3'd1, 12'h0, errNone, 12'h456, 1'b0);
    addRow("read2", opRead, 2'd0, 3'd2, 12'h0, errNone, 12'hABC, 1'b0);
    addRow("readPastEnd", opRead, 2'd0, 3'd5, 12'h0, errOutOfBounds, 12'd0, 1'b0);
    addRow("resize3", opResize, 2'd1, 3'd0, 12'd3, errNone, 12'd0, 1'b0);
    addRow("sizeResized", opSize, 2'd1, 3'd0, 12'h0, errNone, 12'd3, 1'b0);
    addRow("resize9", opResize, 2'd1, 3'd0, 12'd9, errTooLarge, 12'd0, 1'b0);
    addRow("resize6", opResize, 2'd1, 3'd0, 12'd6, errNone, 12'd0, 1'b0);
    addRow("push7", opPush, 2'd1, 3'd0, 12'h077, errNone, 12'd0, 1'b0);
    addRow("push8", opPush, 2'd1, 3'd0, 12'h088, errNone, 12'd0, 1'b0);
    addRow("pushFull", opPush, 2'd1, 3'd0, 12'h099, errFull, 12'd0, 1'b0);
    addRow("pop8", opPop, 2'd1, 3'd0, 12'h0, errNone, 12'h088, 1'b0);  // Last in first
    addRow("pop7", opPop, 2'd1, 3'd0, 12'h0, errNone, 12'h077, 1'b0);
    addRow("popEmpty", opPop, 2'd2, 3'd0, 12'h0, errEmpty, 12'd0, 1'b0);
    addRow("add", opAdd, 2'd0, 3'd1, 12'h100, errNone, 12'h456 + 12'h100, 1'b0);
    addRow("addWrap", opAdd, 2'd0, 3'd2, 12'h600, errNone, 12'hABC + 12'h600, 1'b0);
    addRow("readAdded", opRead, 2'd0, 3'd2, 12'h0, errNone, 12'hABC + 12'h600, 1'b0);
    addRow("free3", opFree, 2'd3, 3'd0, 12'h0, errNone, 12'd0, 1'b0);
    addRow("readFreed", opRead, 2'd3, 3'd0, 12'h0, errNotAllocated, 12'd0, 1'b0);
    addRow("freeTwice", opFree, 2'd3, 3'd0, 12'h0, errNotAllocated, 12'd0, 1'b0);
    addRow("sizeBusy", opSize, 2'd0, 3'd0, 12'h0, errNone, 12'd3, 1'b1);
    addRow("readKept", opRead, 2'd0, 3'd0, 12'h0, errNone, 12'h123, 1'b0);
    addRow("reset", opReset, 2'd0, 3'd0, 12'h0, errNone, 12'd0, 1'b0);
    addRow("size0Reset", opSize, 2'd0, 3'd0, 12'h0, errNotAllocated, 12'd0, 1'b0);
    addRow("size1Reset", opSize, 2'd1, 3'd0, 12'h0, errNotAllocated, 12'd0, 1'b0);
    addRow("size2Reset", opSize, 2'd2, 3'd0, 12'h0, errNotAllocated, 12'd0, 1'b0);
    addRow("size3Reset", opSize, 2'd3, 3'd0, 12'h0, errNotAllocated, 12'd0, 1'b0);
    addRow("allocFresh", opAlloc, 2'd0, 3'd0, 12'h0, errNone, 12'd0, 1'b0);
    addRow("writeNever", opWrite, 2'd1, 3'd0, 12'h5A5, errNotAllocated, 12'd0, 1'b0);
  endtask

  task automatic runRow(input int i);
    logic [31:0] operand;
    logic [31:0] status;
    logic [1:0]  resp;
    heapErr      gotErr;
    operand = '0;
    operand[`HEAP_INDEX_BITS-1:0]  = indexQ[i];
    operand[8 +: `HEAP_ARRAY_BITS] = arrayQ[i];
    writeRegister(AddrOperand, operand, resp);
    checkValue(nameQ[i], "operand response", RespOkay, resp);
    writeRegister(AddrData, {20'd0, dataQ[i]}, resp);
    checkValue(nameQ[i], "data response", RespOkay, resp);
    writeRegister(AddrCommand, {28'd0, opQ[i]}, resp);
    checkValue(nameQ[i], "command response", RespOkay, resp);
    if (overlapQ[i]) begin
      writeRegister(AddrCommand, {28'd0, opReset}, resp);   // Lands before busy clears
      checkValue(nameQ[i], "busy command response", RespSlvErr, resp);
    end
    do begin
      readRegister(AddrStatus, status, resp);
      checkValue(nameQ[i], "status response", RespOkay, resp);
    end while (status[31]);
    gotErr = heapErr'(status[18:16]);
    assert (gotErr == errQ[i]) else begin
      $display("error %s error kind: expected %s, actual %s",
               nameQ[i], errQ[i].name(), gotErr.name());
      reportFailure();
    end
    checkValue(nameQ[i], "result", {20'd0, resultQ[i]}, {20'd0, status[11:0]});
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------
  initial begin
    logic [31:0] status;
    logic [1:0]  resp;
    resetN  = 1'b0;
    awAddr  = '0;
    awValid = 1'b0;
    wData   = '0;
    wStrb   = 4'h0;
    wValid  = 1'b0;
    bReady  = 1'b0;
    arAddr  = '0;
    arValid = 1'b0;
    rReady  = 1'b0;
    buildTable();
    cycleLimit = 60 * nameQ.size() + 100;
    repeat (10) @(posedge clock);
    #StimDelay;
    resetN = 1'b1;
    readRegister(AddrStatus, status, resp);
    checkValue("afterReset", "status response", RespOkay, resp);
    checkValue("afterReset", "status", 32'd0, status);
    foreach (nameQ[i]) runRow(i);
    if (heapUnit_inst.heapRegs_inst.regsChecker.failures == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("protocol checker found %0d violations",
               heapUnit_inst.heapRegs_inst.regsChecker.failures);
      reportFailure();
    end
  end

endmodule

//--- sim/heapUnit_checker.sv
//----------------------------------------
// Register block protocol checker
// Bound to heapRegs, assertions only
//----------------------------------------
`timescale 1ns/100ps

module heapUnit_checker (
  input logic clock,
  input logic resetN,
  input logic bValid,
  input logic bReady,
  input logic rValid,
  input logic rReady,
  input logic start,
  input logic done,
  input logic busy
);

  int unsigned failures = 0;                  // Failed assertions so far

  // Responses wait for the master
  bHold: assert property (@(posedge clock) disable iff (!resetN)
    bValid && !bReady |=> bValid)
    else begin
      $error("write response dropped before bReady");
      failures++;
    end

  rHold: assert property (@(posedge clock) disable iff (!resetN)
    rValid && !rReady |=> rValid)
    else begin
      $error("read data dropped before rReady");
      failures++;
    end

  doneIdle: assert property (@(posedge clock) disable iff (!resetN)
    done |=> !busy)
    else begin
      $error("busy still set after done");
      failures++;
    end

  // One command in flight
  startIdle: assert property (@(posedge clock) disable iff (!resetN)
    start |-> !busy)
    else begin
      $error("command started while busy");
      failures++;
    end

endmodule

bind heapRegs heapUnit_checker regsChecker (
  .clock, .resetN, .bValid, .bReady, .rValid, .rReady, .start, .done, .busy
);

//--- src/heapAllocator.sv
//----------------------------------------
// Array heap allocator
// Freed stack, new counter, allocated flags
//----------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapAllocator (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic [`HEAP_ARRAY_BITS-1:0] array,
  output logic                        allocated,
  output logic [`HEAP_ARRAY_BITS-1:0] freeArray,
  output logic                        haveFree,
  input  logic                        allocate,
  input  logic                        free,
  input  logic                        clearAll
);

  localparam int Arrays = 1 << `HEAP_ARRAY_BITS;

  logic [`HEAP_ARRAY_BITS-1:0] stack [Arrays];   // Freed arrays, newest on top
  logic [`HEAP_ARRAY_BITS:0]   top;              // Entries on the stack
  logic [`HEAP_ARRAY_BITS:0]   nextNew;          // Next never-used array
  logic [Arrays-1:0]           flags;
  logic [`HEAP_ARRAY_BITS-1:0] topIndex;

  assign topIndex  = top[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign allocated = flags[array];
  assign haveFree  = top != '0 || !nextNew[`HEAP_ARRAY_BITS];
  assign freeArray = (top != '0) ? stack[topIndex] : nextNew[`HEAP_ARRAY_BITS-1:0];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      top     <= '0;
      nextNew <= '0;
      flags   <= '0;
    end else if (clearAll) begin
      top     <= '0;
      nextNew <= '0;
      flags   <= '0;
    end else if (allocate) begin
      if (top != '0) top <= top - 1'b1;        // Reuse the latest freed
      else nextNew <= nextNew + 1'b1;
      flags[freeArray] <= 1'b1;
    end else if (free) begin
      top          <= top + 1'b1;
      flags[array] <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (free && !clearAll) stack[top[`HEAP_ARRAY_BITS-1:0]] <= array;
  end

endmodule

//--- src/heapEngine.sv
//----------------------------------------
// Array heap command sequencer
// Checks each command, updates the store
//----------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapEngine import heapPkg::*; (
  input  logic                                          clock,
  input  logic                                          resetN,
  input  logic                                          start,
  input  heapOp                                         op,
  input  logic [`HEAP_ARRAY_BITS-1:0]                   array,
  input  logic [`HEAP_INDEX_BITS-1:0]                   index,
  input  logic [`HEAP_DATA_BITS-1:0]                    data,
  output logic                                          done,
  output heapErr                                        err,
  output logic [`HEAP_DATA_BITS-1:0]                    result,
  output logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0]  rdAddr,
  input  logic [`HEAP_DATA_BITS-1:0]                    rdData,
  output logic                                          wrEn,
  output logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0]  wrAddr,
  output logic [`HEAP_DATA_BITS-1:0]                    wrData,
  input  logic [`HEAP_INDEX_BITS:0]                     size,
  output logic                                          sizeWrEn,
  output logic [`HEAP_INDEX_BITS:0]                     newSize,
  input  logic                                          allocated,
  input  logic [`HEAP_ARRAY_BITS-1:0]                   freeArray,
  input  logic                                          haveFree,
  output logic                                          allocate,
  output logic                                          free,
  output logic                                          clearAll
);

  localparam int Length = 1 << `HEAP_INDEX_BITS;

  engineState                 state;
  heapErr                     errKind;
  logic                       execute;       // Checks passed this cycle
  logic [`HEAP_INDEX_BITS-1:0] lastIndex;
  logic [`HEAP_DATA_BITS-1:0] sum;
  logic [`HEAP_DATA_BITS-1:0] nextResult;

  assign done      = state == stDone;
  assign lastIndex = size[`HEAP_INDEX_BITS-1:0] - 1'b1;
  assign sum       = rdData + data;                     // Wraps at element width
  assign rdAddr    = (op == opPop) ? {array, lastIndex} : {array, index};
  assign execute   = state == stExecute && errKind == errNone;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state  <= stIdle;
      err    <= errNone;
      result <= '0;
    end else begin
      case (state)
        stIdle:   if (start) state <= stLookup;
        stLookup: state <= stExecute;
        stExecute: begin
          state  <= stDone;
          err    <= errKind;
          result <= (errKind == errNone) ? nextResult : '0;
        end
        default:  state <= stIdle;
      endcase
    end
  end

  //----------------------------------------
  // Checks
  //----------------------------------------
  always_comb begin
    errKind = errNone;
    if (op != opReset && op != opAlloc && !allocated) begin
      errKind = errNotAllocated;
    end else begin
      case (op)
        opRead, opAdd: if (index >= size) errKind = errOutOfBounds;
        opPush:        if (size >= Length) errKind = errFull;
        opPop:         if (size == '0) errKind = errEmpty;
        opResize:      if (data > Length) errKind = errTooLarge;
        opAlloc:       if (!haveFree) errKind = errOutOfMemory;
        default:       errKind = errNone;
      endcase
    end
  end

  //----------------------------------------
  // Updates and results
  //----------------------------------------
  always_comb begin
    wrEn       = 1'b0;
    wrAddr     = {array, index};
    wrData     = data;
    sizeWrEn   = 1'b0;
    newSize    = size;
    allocate   = 1'b0;
    free       = 1'b0;
    clearAll   = 1'b0;
    nextResult = '0;
    case (op)
      opWrite: begin
        wrEn       = execute;
        sizeWrEn   = execute && index >= size;   // Grow past the end
        newSize    = {1'b0, index} + 1'b1;
        nextResult = data;
      end
      opRead:  nextResult = rdData;
      opSize:  nextResult = `HEAP_DATA_BITS'(size);
      opResize: begin
        sizeWrEn = execute;
        newSize  = data[`HEAP_INDEX_BITS:0];
      end
      opPush: begin
        wrEn     = execute;
        wrAddr   = {array, size[`HEAP_INDEX_BITS-1:0]};
        sizeWrEn = execute;
        newSize  = size + 1'b1;
      end
      opPop: begin
        sizeWrEn   = execute;
        newSize    = size - 1'b1;
        nextResult = rdData;                     // Element at the old top
      end
      opAdd: begin
        wrEn       = execute;
        wrData     = sum;
        nextResult = sum;
      end
      opAlloc: begin
        allocate   = execute;
        wrAddr     = {freeArray, {`HEAP_INDEX_BITS{1'b0}}};
        sizeWrEn   = execute;                    // New array starts empty
        newSize    = '0;
        nextResult = `HEAP_DATA_BITS'(freeArray);
      end
      opFree:  free = execute;
      default: clearAll = execute;               // Reset
    endcase
  end

endmodule

//--- src/heapPkg.sv
//----------------------------------------
// Array heap types
// Opcodes, error kinds and sequencer states
//----------------------------------------
package heapPkg;

  typedef enum logic [3:0] {
    opReset  = 4'd0,                           // Free every array
    opAlloc  = 4'd1,
    opFree   = 4'd2,
    opWrite  = 4'd3,                           // May extend the size
    opRead   = 4'd4,
    opSize   = 4'd5,
    opResize = 4'd6,
    opPush   = 4'd7,
    opPop    = 4'd8,
    opAdd    = 4'd9                            // Returns the new value
  } heapOp;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,
    errOutOfBounds  = 3'd2,
    errFull         = 3'd3,
    errEmpty        = 3'd4,
    errOutOfMemory  = 3'd5,
    errTooLarge     = 3'd6
  } heapErr;

  typedef enum logic [1:0] {
    stIdle    = 2'd0,
    stLookup  = 2'd1,                          // Element and size read
    stExecute = 2'd2,                          // Checks and updates
    stDone    = 2'd3
  } engineState;

endpackage

//--- src/heapRegs.sv
//----------------------------------------
// Array heap register block
// AXI4-Lite operands, command and status
//----------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapRegs import heapPkg::*; (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic [`HEAP_ADDR_BITS-1:0]  awAddr,
  input  logic                        awValid,
  output logic                        awReady,
  input  logic [31:0]                 wData,
  input  logic [3:0]                  wStrb,
  input  logic                        wValid,
  output logic                        wReady,
  output logic [1:0]                  bResp,
  output logic                        bValid,
  input  logic                        bReady,
  input  logic [`HEAP_ADDR_BITS-1:0]  arAddr,
  input  logic                        arValid,
  output logic                        arReady,
  output logic [31:0]                 rData,
  output logic [1:0]                  rResp,
  output logic                        rValid,
  input  logic                        rReady,
  output logic                        start,
  output heapOp                       op,
  output logic [`HEAP_ARRAY_BITS-1:0] array,
  output logic [`HEAP_INDEX_BITS-1:0] index,
  output logic [`HEAP_DATA_BITS-1:0]  data,
  input  logic                        done,
  input  heapErr                      err,
  input  logic [`HEAP_DATA_BITS-1:0]  result
);

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  logic                       busy;         // Command in flight
  heapErr                     errReg;
  logic [`HEAP_DATA_BITS-1:0] resultReg;
  logic                       wrFire;
  logic                       rdFire;
  logic                       cmdWrite;
  logic                       cmdReject;
  logic                       cmdLaunch;
  logic [31:0]                readWord;

  assign wReady    = awReady;               // AW and W taken together
  assign rResp     = RespOkay;
  assign wrFire    = awReady && awValid && wValid;
  assign rdFire    = arReady && arValid;
  assign cmdWrite  = wrFire && awAddr[3:2] == 2'd2;
  assign cmdReject = cmdWrite && (busy || start);
  assign cmdLaunch = cmdWrite && !cmdReject && wStrb[0];

  //----------------------------------------
  // Write channel
  //----------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      awReady <= 1'b0;
      bValid  <= 1'b0;
      bResp   <= RespOkay;
    end else begin
      awReady <= !awReady && awValid && wValid && !bValid;   // One cycle pulse
      if (wrFire) begin
        bValid <= 1'b1;
        bResp  <= cmdReject ? RespSlvErr : RespOkay;
      end else if (bReady) begin
        bValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      array <= '0;
      index <= '0;
      data  <= '0;
      op    <= opReset;
      start <= 1'b0;
    end else begin
      start <= cmdLaunch;
      if (wrFire && awAddr[3:2] == 2'd0) begin
        if (wStrb[0]) index <= wData[`HEAP_INDEX_BITS-1:0];
        if (wStrb[1]) array <= wData[8 +: `HEAP_ARRAY_BITS];
      end
      if (wrFire && awAddr[3:2] == 2'd1) begin
        if (wStrb[0]) data[7:0] <= wData[7:0];
        if (wStrb[1]) data[`HEAP_DATA_BITS-1:8] <= wData[`HEAP_DATA_BITS-1:8];
      end
      if (cmdLaunch) op <= heapOp'(wData[3:0]);
    end
  end

  // Busy spans start to done
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      busy      <= 1'b0;
      errReg    <= errNone;
      resultReg <= '0;
    end else begin
      if (start) begin
        busy <= 1'b1;
      end else if (done) begin
        busy      <= 1'b0;
        errReg    <= err;
        resultReg <= result;
      end
    end
  end

  //----------------------------------------
  // Read channel
  //----------------------------------------
  always_comb begin
    readWord = '0;
    case (arAddr[3:2])
      2'd0: begin
        readWord[`HEAP_INDEX_BITS-1:0]  = index;
        readWord[8 +: `HEAP_ARRAY_BITS] = array;
      end
      2'd1: readWord[`HEAP_DATA_BITS-1:0] = data;
      2'd2: readWord[3:0] = op;
      default: begin
        readWord[31]                     = busy;
        readWord[18:16]                  = errReg;
        readWord[`HEAP_DATA_BITS-1:0]    = resultReg;
      end
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      arReady <= 1'b0;
      rValid  <= 1'b0;
      rData   <= '0;
    end else begin
      arReady <= !arReady && arValid && !rValid;
      if (rdFire) begin
        rValid <= 1'b1;
        rData  <= readWord;
      end else if (rReady) begin
        rValid <= 1'b0;
      end
    end
  end

endmodule

//--- src/heapStore.sv
//----------------------------------------
// Array heap store
// Element memory and per-array sizes
//----------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapStore (
  input  logic                                          clock,
  input  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0]  rdAddr,
  output logic [`HEAP_DATA_BITS-1:0]                    rdData,
  input  logic                                          wrEn,
  input  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0]  wrAddr,
  input  logic [`HEAP_DATA_BITS-1:0]                    wrData,
  input  logic [`HEAP_ARRAY_BITS-1:0]                   sizeArray,
  output logic [`HEAP_INDEX_BITS:0]                     size,
  input  logic                                          sizeWrEn,
  input  logic [`HEAP_INDEX_BITS:0]                     newSize
);

  localparam int Words  = 1 << (`HEAP_ARRAY_BITS + `HEAP_INDEX_BITS);
  localparam int Arrays = 1 << `HEAP_ARRAY_BITS;

  logic [`HEAP_DATA_BITS-1:0] mem   [Words];    // Array major, index minor
  logic [`HEAP_INDEX_BITS:0]  sizes [Arrays];

  // Element port, one cycle read latency
  always_ff @(posedge clock) begin
    if (wrEn) mem[wrAddr] <= wrData;
    rdData <= mem[rdAddr];
  end

  // Size table shares the array field of wrAddr
  always_ff @(posedge clock) begin
    if (sizeWrEn) sizes[wrAddr[`HEAP_INDEX_BITS +: `HEAP_ARRAY_BITS]] <= newSize;
    size <= sizes[sizeArray];
  end

endmodule

//--- src/heapUnit.sv
//----------------------------------------
// Array heap unit
// AXI4-Lite registers over the heap engine
//----------------------------------------
`timescale 1ns/100ps
`include "heap_config.svh"

module heapUnit import heapPkg::*; (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic [`HEAP_ADDR_BITS-1:0] awAddr,
  input  logic                       awValid,
  output logic                       awReady,
  input  logic [31:0]                wData,
  input  logic [3:0]                 wStrb,
  input  logic                       wValid,
  output logic                       wReady,
  output logic [1:0]                 bResp,
  output logic                       bValid,
  input  logic                       bReady,
  input  logic [`HEAP_ADDR_BITS-1:0] arAddr,
  input  logic                       arValid,
  output logic                       arReady,
  output logic [31:0]                rData,
  output logic [1:0]                 rResp,
  output logic                       rValid,
  input  logic                       rReady
);

  logic                                         start;
  logic                                         done;
  heapOp                                        op;
  heapErr                                       err;
  logic [`HEAP_ARRAY_BITS-1:0]                  array;
  logic [`HEAP_INDEX_BITS-1:0]                  index;
  logic [`HEAP_DATA_BITS-1:0]                   data;
  logic [`HEAP_DATA_BITS-1:0]                   result;
  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] rdAddr;
  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] wrAddr;
  logic [`HEAP_DATA_BITS-1:0]                   rdData;
  logic [`HEAP_DATA_BITS-1:0]                   wrData;
  logic                                         wrEn;
  logic [`HEAP_INDEX_BITS:0]                    size;
  logic [`HEAP_INDEX_BITS:0]                    newSize;
  logic                                         sizeWrEn;
  logic                                         allocated;
  logic [`HEAP_ARRAY_BITS-1:0]                  freeArray;
  logic                                         haveFree;
  logic                                         allocate;
  logic                                         free;
  logic                                         clearAll;

  heapRegs heapRegs_inst (
    .clock, .resetN,
    .awAddr, .awValid, .awReady, .wData, .wStrb, .wValid, .wReady,
    .bResp, .bValid, .bReady,
    .arAddr, .arValid, .arReady, .rData, .rResp, .rValid, .rReady,
    .start, .op, .array, .index, .data, .done, .err, .result
  );

  heapEngine heapEngine_inst (
    .clock, .resetN, .start, .op, .array, .index, .data,
    .done, .err, .result, .rdAddr, .rdData, .wrEn, .wrAddr, .wrData,
    .size, .sizeWrEn, .newSize, .allocated, .freeArray, .haveFree,
    .allocate, .free, .clearAll
  );

  // Operand array addresses the flags and the size table
  heapAllocator heapAllocator_inst (
    .clock, .resetN, .array, .allocated, .freeArray, .haveFree,
    .allocate, .free, .clearAll
  );

  heapStore heapStore_inst (
    .clock, .rdAddr, .rdData, .wrEn, .wrAddr, .wrData,
    .sizeArray (array), .size, .sizeWrEn, .newSize
  );

endmodule

//--- src/heap_config.svh
//----------------------------------------
// Array heap sizing
// Widths shared by the heap unit blocks
//----------------------------------------
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// Array number, 4 arrays
`define HEAP_ARRAY_BITS 2

// Element index, 8 elements per array
`define HEAP_INDEX_BITS 3

// Element width
`define HEAP_DATA_BITS 12

// AXI4-Lite byte address
`define HEAP_ADDR_BITS 4

`endif
